//--- rtl/gpif_consts.svh
`ifndef GPIF_CONSTS_SVH
`define GPIF_CONSTS_SVH

// clock crossing FIFOs for data and responses, 16 lines each.
`define GPIF_CDC_AW 4

// data line FIFO in the gpif domain. It is deep enough to hold whole packets.
`define GPIF_LINE_AW 10

// longest data burst the host may pull, in lines.
`define GPIF_BURST_DATA 256

// longest response burst. It is also the buffered level that clears the
// response empty flag.
`define GPIF_BURST_RESP 16

`endif

//--- rtl/gpif_rd_pkg.sv
package gpif_rd_pkg;

   // one line from the system side.
   // bit 17 is end of packet, bit 16 is start of packet, 15:0 the word.
   typedef logic [17:0] line_t;

   // word on the gpif bus.
   typedef logic [15:0] word_t;

   // complete data packets held in the gpif domain.
   typedef logic [7:0] pkt_cnt_t;

   // read strobes seen since gpif_rd went high.
   typedef logic [8:0] burst_cnt_t;

   // progress of a data burst.
   typedef enum logic [1:0] {
      rd_idle,
      rd_stream,
      rd_pad
   } rd_state_t;

endpackage

//--- rtl/gpif_cdc_fifo.sv
`timescale 1ns/10ps

module gpif_cdc_fifo #(
   parameter int WIDTH = 18,
   parameter int AW    = 4
) (
   input  logic             wclk_i,
   input  logic             wrst_i,
   input  logic [WIDTH-1:0] wdata_i,
   input  logic             wsrc_rdy_i,
   output logic             wdst_rdy_o,
   input  logic             rclk_i,
   input  logic             rrst_i,
   output logic [WIDTH-1:0] rdata_o,
   output logic             rsrc_rdy_o,
   input  logic             rdst_rdy_i,
   output logic [AW:0]      rlevel_o
);

   localparam int DEPTH = 1 << AW;

   logic [WIDTH-1:0] mem [DEPTH];

   // write clock domain.
   logic [AW:0] wbin;
   logic [AW:0] wbin_next;
   logic [AW:0] wgray;
   logic [AW:0] wgray_next;
   logic [AW:0] rgray_w1;
   logic [AW:0] rgray_w2;
   logic [AW:0] wlevel;
   logic        wfull;
   logic        wpush;

   // read clock domain.
   logic [AW:0] rbin;
   logic [AW:0] rbin_next;
   logic [AW:0] rgray;
   logic [AW:0] rgray_next;
   logic [AW:0] wgray_r1;
   logic [AW:0] wgray_r2;
   logic        rempty;
   logic        rpop;

   function automatic logic [AW:0] gray2bin(input logic [AW:0] g);
      logic [AW:0] b;
      b[AW] = g[AW];
      for (int i = AW - 1; i >= 0; i--) begin
         b[i] = b[i+1] ^ g[i];
      end
      return b;
   endfunction

   // full when the pointers differ only in the wrap bits.
   assign wfull      = (wgray == {~rgray_w2[AW:AW-1], rgray_w2[AW-2:0]});
   assign wpush      = wsrc_rdy_i & ~wfull;
   assign wdst_rdy_o = ~wfull;
   assign wbin_next  = wbin + (AW+1)'(wpush);
   assign wgray_next = wbin_next ^ (wbin_next >> 1);
   assign wlevel     = wbin - gray2bin(rgray_w2);   // pessimistic, read side lags.

   always_ff @(posedge wclk_i) begin
      if (wrst_i) begin
         wbin     <= '0;
         wgray    <= '0;
         rgray_w1 <= '0;
         rgray_w2 <= '0;
      end else begin
         wbin     <= wbin_next;
         wgray    <= wgray_next;
         rgray_w1 <= rgray;
         rgray_w2 <= rgray_w1;
      end
   end

   always_ff @(posedge wclk_i) begin
      if (wpush) begin
         mem[wbin[AW-1:0]] <= wdata_i;
      end
   end

   assign rempty     = (rgray == wgray_r2);
   assign rpop       = rdst_rdy_i & ~rempty;
   assign rsrc_rdy_o = ~rempty;
   assign rbin_next  = rbin + (AW+1)'(rpop);
   assign rgray_next = rbin_next ^ (rbin_next >> 1);
   assign rdata_o    = mem[rbin[AW-1:0]];   // head is visible once the pointer arrives.
   assign rlevel_o   = gray2bin(wgray_r2) - rbin;

   always_ff @(posedge rclk_i) begin
      if (rrst_i) begin
         rbin     <= '0;
         rgray    <= '0;
         wgray_r1 <= '0;
         wgray_r2 <= '0;
      end else begin
         rbin     <= rbin_next;
         rgray    <= rgray_next;
         wgray_r1 <= wgray;
         wgray_r2 <= wgray_r1;
      end
   end

   // the writer never gets more than a full memory ahead of the reader.
   a_no_overrun: assert property (@(posedge wclk_i) disable iff (wrst_i)
      wlevel <= (AW+1)'(DEPTH));

   // the reader never passes the write pointer it has seen.
   a_no_underrun: assert property (@(posedge rclk_i) disable iff (rrst_i)
      rlevel_o <= (AW+1)'(DEPTH));

endmodule

//--- rtl/gpif_line_fifo.sv
`timescale 1ns/10ps

module gpif_line_fifo #(
   parameter int WIDTH = 18,
   parameter int AW    = 10
) (
   input  logic               gpif_clk,
   input  logic               gpif_rst,
   input  gpif_rd_pkg::line_t din_i,
   input  logic               push_rdy_i,
   output logic               push_ack_o,
   output gpif_rd_pkg::line_t dout_o,
   output logic               valid_o,
   input  logic               pop_i
);

   localparam int DEPTH = 1 << AW;

   logic [WIDTH-1:0] mem [DEPTH];
   logic [AW-1:0]    wr_ptr;
   logic [AW-1:0]    rd_ptr;
   logic [AW:0]      count;
   logic             full;
   logic             push;

   assign full       = (count == (AW+1)'(DEPTH));
   assign push       = push_rdy_i & ~full;
   assign push_ack_o = push;   // doubles as the transfer strobe.
   assign valid_o    = (count != '0);
   assign dout_o     = mem[rd_ptr];

   always_ff @(posedge gpif_clk) begin
      if (gpif_rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop_i) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({push, pop_i})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   always_ff @(posedge gpif_clk) begin
      if (push) begin
         mem[wr_ptr] <= din_i;
      end
   end

   // the reader only pops a line that is there.
   a_no_pop_empty: assert property (@(posedge gpif_clk) disable iff (gpif_rst)
      pop_i |-> valid_o);

endmodule

//--- rtl/gpif_rd_ctrl.sv
`timescale 1ns/10ps
`include "gpif_consts.svh"

module gpif_rd_ctrl (
   input  logic                  gpif_clk,
   input  logic                  gpif_rst,
   input  logic                  gpif_rd_i,
   input  logic                  gpif_ep_i,
   input  gpif_rd_pkg::line_t    in_line_i,
   input  logic                  in_move_i,
   input  gpif_rd_pkg::line_t    data_line_i,
   input  logic                  data_valid_i,
   output logic                  data_pop_o,
   input  gpif_rd_pkg::line_t    resp_line_i,
   input  logic                  resp_valid_i,
   input  logic [`GPIF_CDC_AW:0] resp_level_i,
   output logic                  resp_pop_o,
   output gpif_rd_pkg::word_t    gpif_data_o,
   output logic                  gpif_empty_d_o,
   output logic                  gpif_empty_c_o
);

   import gpif_rd_pkg::*;

   localparam int EOP = 17;
   localparam int SOP = 16;

   burst_cnt_t burst_cnt;
   pkt_cnt_t   pkt_cnt;
   rd_state_t  state;
   logic       data_room;
   logic       resp_room;
   logic       produce_eop;
   logic       consume_sop;
   word_t      data_word;
   word_t      resp_word;

   assign data_room = (burst_cnt < burst_cnt_t'(`GPIF_BURST_DATA));
   assign resp_room = (burst_cnt < burst_cnt_t'(`GPIF_BURST_RESP));

   assign data_pop_o = gpif_rd_i & ~gpif_ep_i & data_room & (state != rd_pad) & data_valid_i;
   assign resp_pop_o = gpif_rd_i & gpif_ep_i & resp_room & resp_valid_i;

   assign produce_eop = in_move_i & in_line_i[EOP];   // packet complete in line fifo.
   assign consume_sop = data_pop_o & data_line_i[SOP];

   assign data_word   = (state != rd_pad && data_valid_i) ? data_line_i[15:0] : '0;
   assign resp_word   = resp_valid_i ? resp_line_i[15:0] : '0;
   assign gpif_data_o = gpif_ep_i ? resp_word : data_word;

   // strobes in the current burst, held at the top.
   always_ff @(posedge gpif_clk) begin
      if (gpif_rst || !gpif_rd_i) begin
         burst_cnt <= '0;
      end else if (burst_cnt != '1) begin
         burst_cnt <= burst_cnt + 1'b1;
      end
   end

   always_ff @(posedge gpif_clk) begin
      if (gpif_rst || !gpif_rd_i) begin
         state <= rd_idle;
      end else begin
         case (state)
            rd_idle, rd_stream: begin
               if (data_pop_o && data_line_i[EOP]) begin
                  state <= rd_pad;   // rest of the burst is filler.
               end else if (data_pop_o) begin
                  state <= rd_stream;
               end
            end
            default: state <= rd_pad;
         endcase
      end
   end

   always_ff @(posedge gpif_clk) begin
      if (gpif_rst) begin
         pkt_cnt <= '0;
      end else if (produce_eop && !consume_sop) begin
         pkt_cnt <= pkt_cnt + 1'b1;
      end else if (consume_sop && !produce_eop) begin
         pkt_cnt <= pkt_cnt - 1'b1;
      end
   end

   always_ff @(posedge gpif_clk) begin
      if (gpif_rst) begin
         gpif_empty_d_o <= 1'b1;
         gpif_empty_c_o <= 1'b1;
      end else begin
         gpif_empty_d_o <= (pkt_cnt == '0);
         gpif_empty_c_o <= (resp_level_i < (`GPIF_CDC_AW+1)'(`GPIF_BURST_RESP));
      end
   end

   a_pkt_no_overflow: assert property (@(posedge gpif_clk) disable iff (gpif_rst)
      (pkt_cnt == '1) |-> !(produce_eop && !consume_sop));

   // host must not start a packet that has not fully arrived.
   a_pkt_no_underflow: assert property (@(posedge gpif_clk) disable iff (gpif_rst)
      (pkt_cnt == '0) |-> !(consume_sop && !produce_eop));

   // after an end line the burst only pads.
   a_pad_no_pop: assert property (@(posedge gpif_clk) disable iff (gpif_rst)
      (data_pop_o && data_line_i[EOP]) |=> !data_pop_o);

endmodule

//--- rtl/gpif_rd.sv
`timescale 1ns/10ps
`include "gpif_consts.svh"

module gpif_rd (
   input  logic               gpif_clk,
   input  logic               gpif_rst,
   input  logic               gpif_rd_i,
   input  logic               gpif_ep_i,
   output gpif_rd_pkg::word_t gpif_data_o,
   output logic               gpif_empty_d_o,
   output logic               gpif_empty_c_o,
   input  logic               sys_clk,
   input  logic               sys_rst,
   input  gpif_rd_pkg::line_t data_i,
   input  logic               src_rdy_i,
   output logic               dst_rdy_o,
   input  gpif_rd_pkg::line_t resp_i,
   input  logic               resp_src_rdy_i,
   output logic               resp_dst_rdy_o
);

   import gpif_rd_pkg::*;

   line_t                 data_int;
   logic                  data_int_rdy;
   logic                  data_int_move;
   line_t                 data_head;
   logic                  data_valid;
   logic                  data_pop;
   line_t                 resp_head;
   logic                  resp_valid;
   logic                  resp_pop;
   logic [`GPIF_CDC_AW:0] resp_level;

   gpif_cdc_fifo #(.WIDTH($bits(line_t)), .AW(`GPIF_CDC_AW)) data_cdc (
      .wclk_i(sys_clk), .wrst_i(sys_rst),
      .wdata_i(data_i), .wsrc_rdy_i(src_rdy_i), .wdst_rdy_o(dst_rdy_o),
      .rclk_i(gpif_clk), .rrst_i(gpif_rst),
      .rdata_o(data_int), .rsrc_rdy_o(data_int_rdy), .rdst_rdy_i(data_int_move),
      .rlevel_o()
   );

   gpif_line_fifo #(.WIDTH($bits(line_t)), .AW(`GPIF_LINE_AW)) line_fifo (
      .gpif_clk(gpif_clk), .gpif_rst(gpif_rst),
      .din_i(data_int), .push_rdy_i(data_int_rdy), .push_ack_o(data_int_move),
      .dout_o(data_head), .valid_o(data_valid), .pop_i(data_pop)
   );

   gpif_cdc_fifo #(.WIDTH($bits(line_t)), .AW(`GPIF_CDC_AW)) resp_cdc (
      .wclk_i(sys_clk), .wrst_i(sys_rst),
      .wdata_i(resp_i), .wsrc_rdy_i(resp_src_rdy_i), .wdst_rdy_o(resp_dst_rdy_o),
      .rclk_i(gpif_clk), .rrst_i(gpif_rst),
      .rdata_o(resp_head), .rsrc_rdy_o(resp_valid), .rdst_rdy_i(resp_pop),
      .rlevel_o(resp_level)
   );

   gpif_rd_ctrl ctrl (
      .gpif_clk(gpif_clk), .gpif_rst(gpif_rst),
      .gpif_rd_i(gpif_rd_i), .gpif_ep_i(gpif_ep_i),
      .in_line_i(data_int), .in_move_i(data_int_move),
      .data_line_i(data_head), .data_valid_i(data_valid), .data_pop_o(data_pop),
      .resp_line_i(resp_head), .resp_valid_i(resp_valid),
      .resp_level_i(resp_level), .resp_pop_o(resp_pop),
      .gpif_data_o(gpif_data_o),
      .gpif_empty_d_o(gpif_empty_d_o), .gpif_empty_c_o(gpif_empty_c_o)
   );

endmodule

//--- bench/gpif_rd_tb.sv
`timescale 1ns/10ps
`include "gpif_consts.svh"

module gpif_rd_tb;

   import gpif_rd_pkg::*;

   localparam int ROWS       = 8;
   localparam int LIMIT      = 5000;    // gpif cycles for one wait.
   localparam int SEND_LIMIT = 20000;   // sys cycles for one line.
   localparam int WAIT_PKT   = 0;
   localparam int WAIT_RESP  = 1;
   localparam int WAIT_FULL  = 2;

   // endpoint, lines, first word, reads per burst.
   logic row_ep    [ROWS] = '{1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1};
   int   row_len   [ROWS] = '{5, 1, 16, 300, 40, 200, 600, 16};
   int   row_start [ROWS] = '{'h1000, 'h2000, 'h3000, 'h4000, 'h5000, 'h6000, 'h7000, 'h8000};
   int   row_reads [ROWS] = '{8, 3, 20, 270, 40, 256, 300, 20};

   logic  gpif_clk;
   logic  gpif_rst;
   logic  gpif_rd;
   logic  gpif_ep;
   word_t gpif_data_o;
   logic  gpif_empty_d_o;
   logic  gpif_empty_c_o;
   logic  sys_clk;
   logic  sys_rst;
   line_t data_i;
   logic  src_rdy_i;
   logic  dst_rdy_o;
   line_t resp_i;
   logic  resp_src_rdy_i;
   logic  resp_dst_rdy_o;

   int checks        = 0;
   int errors        = 0;
   int level_errors  = 0;
   int timeouts      = 0;
   int feed_timeouts = 0;
   int resp_sent     = 0;
   int resp_read     = 0;
   int seed          = 54646;
   bit saw_full      = 1'b0;
   bit resp_busy     = 1'b0;

   gpif_rd gpif_rd_i (
      .gpif_clk(gpif_clk), .gpif_rst(gpif_rst), .gpif_rd_i(gpif_rd), .gpif_ep_i(gpif_ep),
      .gpif_data_o(gpif_data_o), .gpif_empty_d_o(gpif_empty_d_o),
      .gpif_empty_c_o(gpif_empty_c_o),
      .sys_clk(sys_clk), .sys_rst(sys_rst),
      .data_i(data_i), .src_rdy_i(src_rdy_i), .dst_rdy_o(dst_rdy_o),
      .resp_i(resp_i), .resp_src_rdy_i(resp_src_rdy_i), .resp_dst_rdy_o(resp_dst_rdy_o)
   );

   initial begin
      gpif_clk = 1'b0;
      forever #4 gpif_clk = ~gpif_clk;
   end

   initial begin
      sys_clk = 1'b0;
      forever #5 sys_clk = ~sys_clk;
   end

   task automatic compare_word(input string name, input word_t got, input word_t exp);
      checks++;
      assert (got == exp) else begin
         errors++;
         $display("Error at %0d ns: %s is %h, expected %h", $time, name, got, exp);
      end
   endtask

   task automatic expect_flag(input string name, input logic got, input logic exp);
      checks++;
      assert (got == exp) else begin
         errors++;
         $display("Error at %0d ns: %s is %b, expected %b", $time, name, got, exp);
      end
   endtask

   task automatic wait_for(input int cond, input string what);
      int t;
      bit hit;
      t = 0;
      hit = 1'b0;
      while (!hit && t < LIMIT) begin
         @(negedge gpif_clk);
         t++;
         case (cond)
            WAIT_PKT:  hit = !gpif_empty_d_o;
            WAIT_RESP: hit = !gpif_empty_c_o;
            default:   hit = saw_full;
         endcase
      end
      if (!hit) begin
         timeouts++;
         $display("Timeout after %0d cycles waiting for %s", LIMIT, what);
      end
   endtask

   // one strobe; the word is sampled well before the rising edge that pops it.
   task automatic read_cycle(input logic ep, output word_t got);
      @(negedge gpif_clk);
      gpif_rd = 1'b1;
      gpif_ep = ep;
      #2;
      got = gpif_data_o;
   endtask

   task automatic end_burst();
      @(negedge gpif_clk);
      gpif_rd = 1'b0;
      gpif_ep = 1'b0;
   endtask

   task automatic data_burst(input int row, inout int idx);
      word_t exp;
      word_t got;
      bit    pad;
      pad = 1'b0;
      for (int i = 0; i < row_reads[row]; i++) begin
         exp = pad ? word_t'(0) : word_t'(row_start[row] + idx);
         read_cycle(1'b0, got);
         compare_word("gpif_data_o", got, exp);
         if (!pad && i < `GPIF_BURST_DATA) begin
            pad = (idx == row_len[row] - 1);   // end line, filler follows.
            idx++;
         end
      end
      end_burst();
   endtask

   task automatic resp_burst(input int row, inout int idx);
      word_t exp;
      word_t got;
      for (int i = 0; i < row_reads[row]; i++) begin
         if (i < `GPIF_BURST_RESP && idx < row_len[row]) begin
            exp = word_t'(row_start[row] + idx);
            idx++;
            resp_read++;
         end else begin
            exp = word_t'(0);   // nothing left in the crossing fifo.
         end
         read_cycle(1'b1, got);
         compare_word("gpif_data_o", got, exp);
      end
      end_burst();
   endtask

   // dst_rdy only moves on the rising edge, so it is settled here.
   task automatic send_line(input logic ep, input line_t l);
      int t;
      bit done;
      t = 0;
      done = 1'b0;
      while (!done && t < SEND_LIMIT) begin
         @(negedge sys_clk);
         t++;
         data_i = line_t'($random(seed));
         resp_i = line_t'($random(seed));
         src_rdy_i = 1'b0;
         resp_src_rdy_i = 1'b0;
         if (($random(seed) & 3) != 0) begin
            if (ep) begin
               resp_i = l;
               resp_src_rdy_i = 1'b1;
               done = resp_dst_rdy_o;
            end else begin
               data_i = l;
               src_rdy_i = 1'b1;
               done = dst_rdy_o;
            end
         end
      end
      if (!done) begin
         feed_timeouts++;
         $display("Timeout: the feeder could not hand over a line in %0d cycles", SEND_LIMIT);
      end else if (ep) begin
         resp_sent++;
      end
   endtask

   initial begin
      sys_rst = 1'b1;
      src_rdy_i = 1'b0;
      resp_src_rdy_i = 1'b0;
      data_i = '0;
      resp_i = '0;
      repeat (4) @(negedge sys_clk);
      sys_rst = 1'b0;
      for (int r = 0; r < ROWS && feed_timeouts == 0; r++) begin
         for (int i = 0; i < row_len[r] && feed_timeouts == 0; i++) begin
            send_line(row_ep[r], {i == row_len[r] - 1, i == 0, word_t'(row_start[r] + i)});
         end
      end
      @(negedge sys_clk);
      src_rdy_i = 1'b0;
      resp_src_rdy_i = 1'b0;
   end

   always @(negedge sys_clk) begin
      if (!sys_rst && !dst_rdy_o) begin
         saw_full = 1'b1;
      end
   end

   // response flag may only drop with a full burst buffered.
   always @(negedge gpif_clk) begin
      if (!gpif_rst && !resp_busy && !gpif_empty_c_o) begin
         assert (resp_sent - resp_read >= `GPIF_BURST_RESP) else begin
            level_errors++;
            $display("Error at %0d ns: gpif_empty_c_o is 0, expected 1 (%0d lines buffered)",
                     $time, resp_sent - resp_read);
         end
      end
   end

   initial begin
      int idx;
      gpif_rst = 1'b1;
      gpif_rd = 1'b0;
      gpif_ep = 1'b0;
      repeat (4) @(negedge gpif_clk);
      gpif_rst = 1'b0;
      expect_flag("gpif_empty_d_o", gpif_empty_d_o, 1'b1);
      expect_flag("gpif_empty_c_o", gpif_empty_c_o, 1'b1);
      expect_flag("dst_rdy_o", dst_rdy_o, 1'b1);
      expect_flag("resp_dst_rdy_o", resp_dst_rdy_o, 1'b1);
      wait_for(WAIT_PKT, "the first data packet");
      wait_for(WAIT_FULL, "back-pressure on dst_rdy_o");   // reader stays idle until then.
      for (int r = 0; r < ROWS && timeouts == 0; r++) begin
         idx = 0;
         if (row_ep[r]) begin
            wait_for(WAIT_RESP, "16 buffered response lines");
            resp_busy = 1'b1;
            while (idx < row_len[r] && timeouts == 0) begin
               resp_burst(r, idx);
            end
            resp_busy = 1'b0;
         end else begin
            wait_for(WAIT_PKT, "a complete data packet");
            while (idx < row_len[r] && timeouts == 0) begin
               data_burst(r, idx);
            end
         end
      end
      @(negedge gpif_clk);
      #2;
      expect_flag("gpif_empty_d_o", gpif_empty_d_o, 1'b1);
      expect_flag("gpif_empty_c_o", gpif_empty_c_o, 1'b1);
      compare_word("gpif_data_o", gpif_data_o, word_t'(0));   // no stray line left.
      $display("checks %0d, value errors %0d, level errors %0d, timeouts %0d",
               checks, errors, level_errors, timeouts + feed_timeouts);
      if (errors + level_errors + timeouts + feed_timeouts == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule

//--- list.f
+incdir+rtl
rtl/gpif_rd_pkg.sv
rtl/gpif_cdc_fifo.sv
rtl/gpif_line_fifo.sv
rtl/gpif_rd_ctrl.sv
rtl/gpif_rd.sv
bench/gpif_rd_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f list.f --top-module gpif_rd_tb -o gpif_rd_sim

out=$(./obj_dir/gpif_rd_sim)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx '>>> PASS'; then
   exit 0
fi
exit 1
